// File: run_sim.sh
#!/usr/bin/env bash
# Build the control unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f sim.f \
    --top-module tb_cpu_control -o tb_cpu_control_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_cpu_control_sim 2>&1 | tee sim.log

grep -qF "*** TEST PASSED ***" sim.log \
    && echo "Simulation PASS" \
    || { echo "Simulation FAIL, see sim.log"; exit 1; }

// File: sim.f
+incdir+test
src/cpu_isa_pkg.sv
src/cpu_ctrl_pkg.sv
src/opcode_decoder.sv
src/flow_sequencer.sv
src/ctrl_merge.sv
src/cpu_control.sv
test/tb_clock_gen.sv
test/tb_cpu_control.sv

// File: src/cpu_control.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_control (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [7:0]               opcode_early,   // One clock ahead of cycle 0
    input  logic [2:0]               m_cycle,
    input  logic                     f_z,
    input  logic                     f_c,
    output cpu_ctrl_pkg::ctrl_word_t ctrl
);

    import cpu_ctrl_pkg::*;

    dp_word_t   dp_word;
    flow_word_t flow_word;

    opcode_decoder u_opcode_decoder (
        .clk          (clk),
        .arst_n       (arst_n),
        .opcode_early (opcode_early),
        .dp_word      (dp_word)
    );

    flow_sequencer u_flow_sequencer (
        .clk          (clk),
        .arst_n       (arst_n),
        .opcode_early (opcode_early),
        .m_cycle      (m_cycle),
        .f_z          (f_z),
        .f_c          (f_c),
        .flow_word    (flow_word)
    );

    ctrl_merge u_ctrl_merge (
        .dp_word   (dp_word),
        .flow_word (flow_word),
        .ctrl      (ctrl)
    );

endmodule

`default_nettype wire

// File: src/cpu_ctrl_pkg.sv
`default_nettype none

package cpu_ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus and PC selects
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        bus_idle  = 2'b00,
        bus_fetch = 2'b01,   // Opcode fetch, PC + 1
        bus_write = 2'b10,
        bus_read  = 2'b11
    } bus_op_t;

    typedef enum logic {
        ab_pc = 1'b0,
        ab_sp = 1'b1
    } ab_src_t;

    typedef enum logic [1:0] {
        pc_seq   = 2'b00,
        pc_stack = 2'b01,   // Return address popped from stack
        pc_temp  = 2'b10    // Target gathered in temp register
    } pc_src_t;

    //////////////////////////////////////////////////////////////////////
    // Control words
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        cpu_isa_pkg::alu_op_t  alu_op;
        cpu_isa_pkg::reg_idx_t rf_rd_sel;
        cpu_isa_pkg::reg_idx_t rf_wr_sel;
        logic                  rf_we;
        logic                  flags_we;
    } dp_word_t;

    typedef struct packed {
        bus_op_t bus_op;
        ab_src_t ab_src;
        pc_src_t pc_src;
        logic    pc_we;
        logic    pc_jr;
        logic    next;    // Instruction continues next machine cycle
        logic    halt;
        logic    stop;
    } flow_word_t;

    // Datapath fields first, then flow fields
    typedef struct packed {
        cpu_isa_pkg::alu_op_t  alu_op;
        cpu_isa_pkg::reg_idx_t rf_rd_sel;
        cpu_isa_pkg::reg_idx_t rf_wr_sel;
        logic                  rf_we;
        logic                  flags_we;
        bus_op_t               bus_op;
        ab_src_t               ab_src;
        pc_src_t               pc_src;
        logic                  pc_we;
        logic                  pc_jr;
        logic                  next;
        logic                  halt;
        logic                  stop;
    } ctrl_word_t;

endpackage

`default_nettype wire

// File: src/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

    //////////////////////////////////////////////////////////////////////
    // Instruction classes and operand fields
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        class_nop,
        class_ld_rr,
        class_alu_r,
        class_halt,
        class_stop,
        class_jr,
        class_jp,
        class_call,
        class_ret,
        class_invalid
    } op_class_t;

    // Low two bits follow opcode bits 4:3 of the conditional forms
    typedef enum logic [2:0] {
        cond_nz,
        cond_z,
        cond_nc,
        cond_c,
        cond_always
    } cond_t;

    // First eight follow opcode bits 5:3 of the 80-BF block
    typedef enum logic [3:0] {
        alu_add,
        alu_adc,
        alu_sub,
        alu_sbc,
        alu_and,
        alu_xor,
        alu_or,
        alu_cp,
        alu_pass
    } alu_op_t;

    // Encoding order B C D E H L (HL) A
    typedef logic [2:0] reg_idx_t;

    localparam reg_idx_t reg_b   = 3'd0;
    localparam reg_idx_t reg_mem = 3'd6;   // Memory operand slot, not a register
    localparam reg_idx_t reg_a   = 3'd7;

    //////////////////////////////////////////////////////////////////////
    // Opcodes
    //////////////////////////////////////////////////////////////////////

    localparam logic [7:0] op_nop  = 8'h00;
    localparam logic [7:0] op_stop = 8'h10;
    localparam logic [7:0] op_halt = 8'h76;
    localparam logic [7:0] op_jr   = 8'h18;
    localparam logic [7:0] op_jp   = 8'hc3;
    localparam logic [7:0] op_call = 8'hcd;
    localparam logic [7:0] op_ret  = 8'hc9;

    localparam int n_invalid_ops = 10;
    localparam logic [9:0][7:0] op_invalid_list = {
        8'hd3, 8'he4, 8'hf4, 8'hdb, 8'heb,
        8'hce, 8'hcf, 8'hdd, 8'hde, 8'hdf
    };

    function automatic op_class_t op_class_of(input logic [7:0] op);
        op_class_t cls;
        logic      listed;
        listed = 1'b0;
        for (int i = 0; i < n_invalid_ops; i++) begin
            if (op == op_invalid_list[i]) listed = 1'b1;
        end
        cls = class_invalid;   // Anything not matched below
        if (!listed) begin
            casez (op)
                op_nop:  cls = class_nop;
                op_stop: cls = class_stop;
                op_halt: cls = class_halt;   // Must precede the LD block
                8'b01??????: begin
                    if (op[2:0] != reg_mem && op[5:3] != reg_mem) cls = class_ld_rr;
                end
                8'b10??????: begin
                    if (op[2:0] != reg_mem) cls = class_alu_r;
                end
                op_jr, 8'b001??000:   cls = class_jr;
                op_jp, 8'b110??010:   cls = class_jp;
                op_call, 8'b110??100: cls = class_call;
                op_ret, 8'b110??000:  cls = class_ret;
                default: ;
            endcase
        end
        return cls;
    endfunction

    function automatic cond_t cond_of(input logic [7:0] op);
        if (op == op_jr || op == op_jp || op == op_call || op == op_ret) begin
            return cond_always;
        end
        return cond_t'({1'b0, op[4:3]});
    endfunction

endpackage

`default_nettype wire

// File: src/ctrl_merge.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_merge (
    input  cpu_ctrl_pkg::dp_word_t   dp_word,
    input  cpu_ctrl_pkg::flow_word_t flow_word,
    output cpu_ctrl_pkg::ctrl_word_t ctrl
);

    import cpu_ctrl_pkg::*;

    logic wb_ok;

    // Write back only in the final cycle, and never on halt/stop/trap
    assign wb_ok = !flow_word.next && !flow_word.halt && !flow_word.stop;

    always_comb begin
        ctrl.alu_op    = dp_word.alu_op;
        ctrl.rf_rd_sel = dp_word.rf_rd_sel;
        ctrl.rf_wr_sel = dp_word.rf_wr_sel;
        ctrl.rf_we     = dp_word.rf_we && wb_ok;
        ctrl.flags_we  = dp_word.flags_we && wb_ok;

        ctrl.bus_op    = flow_word.bus_op;
        ctrl.ab_src    = flow_word.ab_src;
        ctrl.pc_src    = flow_word.pc_src;
        ctrl.pc_we     = flow_word.pc_we;
        ctrl.pc_jr     = flow_word.pc_jr;
        ctrl.next      = flow_word.next;
        ctrl.halt      = flow_word.halt;
        ctrl.stop      = flow_word.stop;
    end

endmodule

`default_nettype wire

// File: src/flow_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module flow_sequencer (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [7:0]              opcode_early,
    input  logic [2:0]              m_cycle,
    input  logic                    f_z,
    input  logic                    f_c,
    output cpu_ctrl_pkg::flow_word_t flow_word
);

    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    // Last cycle of an instruction, overlapped with the next fetch
    localparam flow_word_t flow_end = '{
        bus_op: bus_fetch,
        ab_src: ab_pc,
        pc_src: pc_seq,
        pc_we:  1'b0,
        pc_jr:  1'b0,
        next:   1'b0,
        halt:   1'b0,
        stop:   1'b0
    };

    // Illegal machine cycle
    localparam flow_word_t flow_trap = '{
        bus_op: bus_fetch,
        ab_src: ab_pc,
        pc_src: pc_seq,
        pc_we:  1'b0,
        pc_jr:  1'b0,
        next:   1'b1,
        halt:   1'b1,
        stop:   1'b1
    };

    op_class_t op_class;
    cond_t     cond;
    logic      cond_ok;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_class <= class_nop;
            cond     <= cond_always;
        end else begin
            op_class <= op_class_of(opcode_early);
            cond     <= cond_of(opcode_early);
        end
    end

    always_comb begin
        case (cond)
            cond_nz: cond_ok = !f_z;
            cond_z:  cond_ok = f_z;
            cond_nc: cond_ok = !f_c;
            cond_c:  cond_ok = f_c;
            default: cond_ok = 1'b1;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Per machine cycle bus and PC flow
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        flow_word = flow_end;
        case (m_cycle)
            3'd0: begin
                case (op_class)
                    class_halt: flow_word.halt = 1'b1;
                    class_stop: flow_word.stop = 1'b1;
                    class_invalid: begin
                        flow_word.halt = 1'b1;
                        flow_word.stop = 1'b1;
                    end
                    class_jr, class_jp, class_call, class_ret: flow_word.next = 1'b1;
                    default: ;   // Single cycle ops end here
                endcase
            end
            3'd1: begin
                case (op_class)
                    class_jr: begin
                        if (cond_ok) begin
                            flow_word.bus_op = bus_read;   // Offset byte
                            flow_word.pc_jr  = 1'b1;
                            flow_word.next   = 1'b1;
                        end
                    end
                    class_jp, class_call: begin
                        flow_word.bus_op = bus_read;   // Target low byte
                        flow_word.next   = 1'b1;
                    end
                    class_ret: begin
                        if (cond_ok) begin
                            flow_word.bus_op = bus_read;
                            flow_word.ab_src = ab_sp;
                            flow_word.next   = 1'b1;
                        end
                    end
                    default: flow_word = flow_trap;
                endcase
            end
            3'd2: begin
                case (op_class)
                    class_jr: ;
                    class_jp: begin
                        if (cond_ok) begin
                            flow_word.bus_op = bus_idle;
                            flow_word.pc_src = pc_temp;
                            flow_word.pc_we  = 1'b1;
                            flow_word.next   = 1'b1;
                        end
                    end
                    class_call: begin
                        if (cond_ok) begin
                            flow_word.bus_op = bus_idle;   // SP predecrement
                            flow_word.next   = 1'b1;
                        end
                    end
                    class_ret: begin
                        flow_word.bus_op = bus_read;
                        flow_word.ab_src = ab_sp;
                        flow_word.next   = 1'b1;
                    end
                    default: flow_word = flow_trap;
                endcase
            end
            3'd3: begin
                case (op_class)
                    class_jp: ;
                    class_call: begin
                        flow_word.bus_op = bus_write;   // Return address high
                        flow_word.ab_src = ab_sp;
                        flow_word.next   = 1'b1;
                    end
                    class_ret: begin
                        flow_word.bus_op = bus_idle;
                        flow_word.pc_src = pc_stack;
                        flow_word.pc_we  = 1'b1;
                        flow_word.next   = 1'b1;
                    end
                    default: flow_word = flow_trap;
                endcase
            end
            3'd4: begin
                case (op_class)
                    class_call: begin
                        flow_word.bus_op = bus_write;   // Return address low
                        flow_word.ab_src = ab_sp;
                        flow_word.pc_src = pc_temp;
                        flow_word.pc_we  = 1'b1;
                        flow_word.next   = 1'b1;
                    end
                    class_ret: ;
                    default: flow_word = flow_trap;
                endcase
            end
            3'd5: begin
                if (op_class != class_call) flow_word = flow_trap;
            end
            default: flow_word = flow_trap;
        endcase
    end

endmodule

`default_nettype wire

// File: src/opcode_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module opcode_decoder (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [7:0]            opcode_early,
    output cpu_ctrl_pkg::dp_word_t dp_word
);

    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    localparam dp_word_t dp_idle = '{
        alu_op:    alu_pass,
        rf_rd_sel: reg_b,
        rf_wr_sel: reg_b,
        rf_we:     1'b0,
        flags_we:  1'b0
    };

    op_class_t early_class;
    dp_word_t  dp_next;

    //////////////////////////////////////////////////////////////////////
    // First-cycle decode from the opcode bit fields
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        early_class = op_class_of(opcode_early);
        dp_next     = dp_idle;
        case (early_class)
            class_ld_rr: begin
                dp_next.rf_rd_sel = opcode_early[2:0];   // Source
                dp_next.rf_wr_sel = opcode_early[5:3];   // Destination
                dp_next.rf_we     = 1'b1;
            end
            class_alu_r: begin
                dp_next.alu_op    = alu_op_t'({1'b0, opcode_early[5:3]});
                dp_next.rf_rd_sel = opcode_early[2:0];
                dp_next.rf_wr_sel = reg_a;               // Accumulator
                dp_next.flags_we  = 1'b1;
                // CP only updates flags
                dp_next.rf_we     = (opcode_early[5:3] != 3'd7);
            end
            default: ;   // Idle word for everything else
        endcase
    end

    // Word is registered so it lines up with machine cycle 0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dp_word <= dp_idle;   // Same as NOP
        end else begin
            dp_word <= dp_next;
        end
    end

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int half_period  = 20,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Release between edges, well clear of the rising edge
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #(half_period / 2) arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: test/tb_control_model.svh
`ifndef TB_CONTROL_MODEL_SVH
`define TB_CONTROL_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Opcode classification by value ranges
//////////////////////////////////////////////////////////////////////

function automatic op_class_t decode_class(input logic [7:0] opc);
    logic [2:0] src;
    logic [2:0] dst;
    src = opc[2:0];
    dst = opc[5:3];
    if (opc == 8'h00) return class_nop;
    if (opc == 8'h10) return class_stop;
    if (opc == 8'h76) return class_halt;
    if (opc >= 8'h40 && opc <= 8'h7f) begin
        if (src != 3'd6 && dst != 3'd6) return class_ld_rr;
        return class_invalid;   // (HL) forms are dropped
    end
    if (opc >= 8'h80 && opc <= 8'hbf) begin
        if (src != 3'd6) return class_alu_r;
        return class_invalid;
    end
    case (opc)
        8'h18, 8'h20, 8'h28, 8'h30, 8'h38: return class_jr;
        8'hc3, 8'hc2, 8'hca, 8'hd2, 8'hda: return class_jp;
        8'hcd, 8'hc4, 8'hcc, 8'hd4, 8'hdc: return class_call;
        8'hc9, 8'hc0, 8'hc8, 8'hd0, 8'hd8: return class_ret;
        default: return class_invalid;
    endcase
endfunction

function automatic cond_t branch_cond(input logic [7:0] opc);
    case (opc)
        8'h20, 8'hc2, 8'hc4, 8'hc0: return cond_nz;
        8'h28, 8'hca, 8'hcc, 8'hc8: return cond_z;
        8'h30, 8'hd2, 8'hd4, 8'hd0: return cond_nc;
        8'h38, 8'hda, 8'hdc, 8'hd8: return cond_c;
        default: return cond_always;
    endcase
endfunction

function automatic logic cond_taken(input cond_t cnd, input logic z, input logic c);
    case (cnd)
        cond_nz: return !z;
        cond_z:  return z;
        cond_nc: return !c;
        cond_c:  return c;
        default: return 1'b1;
    endcase
endfunction

//////////////////////////////////////////////////////////////////////
// Expected datapath and flow words
//////////////////////////////////////////////////////////////////////

function automatic dp_word_t datapath_word(input logic [7:0] opc);
    dp_word_t  w;
    op_class_t cls;
    cls = decode_class(opc);
    w.alu_op    = alu_pass;
    w.rf_rd_sel = 3'd0;
    w.rf_wr_sel = 3'd0;
    w.rf_we     = 1'b0;
    w.flags_we  = 1'b0;
    if (cls == class_ld_rr) begin
        w.rf_rd_sel = opc[2:0];
        w.rf_wr_sel = opc[5:3];
        w.rf_we     = 1'b1;
    end else if (cls == class_alu_r) begin
        case (opc[5:3])
            3'd0:    w.alu_op = alu_add;
            3'd1:    w.alu_op = alu_adc;
            3'd2:    w.alu_op = alu_sub;
            3'd3:    w.alu_op = alu_sbc;
            3'd4:    w.alu_op = alu_and;
            3'd5:    w.alu_op = alu_xor;
            3'd6:    w.alu_op = alu_or;
            default: w.alu_op = alu_cp;
        endcase
        w.rf_rd_sel = opc[2:0];
        w.rf_wr_sel = 3'd7;                  // A
        w.flags_we  = 1'b1;
        w.rf_we     = (w.alu_op != alu_cp);
    end
    return w;
endfunction

function automatic flow_word_t flow_of(input bus_op_t bus, input ab_src_t ab,
                                       input pc_src_t pc, input logic we,
                                       input logic jr, input logic nxt);
    flow_word_t w;
    w.bus_op = bus;
    w.ab_src = ab;
    w.pc_src = pc;
    w.pc_we  = we;
    w.pc_jr  = jr;
    w.next   = nxt;
    w.halt   = 1'b0;
    w.stop   = 1'b0;
    return w;
endfunction

function automatic flow_word_t flow_expect(input op_class_t cls, input logic taken,
                                           input logic [2:0] m);
    flow_word_t end_w;
    flow_word_t w;
    end_w = flow_of(bus_fetch, ab_pc, pc_seq, 1'b0, 1'b0, 1'b0);
    w      = end_w;
    w.next = 1'b1;    // Trap unless a rule below matches
    w.halt = 1'b1;
    w.stop = 1'b1;
    if (m == 3'd0) begin
        w      = end_w;
        w.halt = (cls == class_halt) || (cls == class_invalid);
        w.stop = (cls == class_stop) || (cls == class_invalid);
        w.next = (cls == class_jr) || (cls == class_jp) ||
                 (cls == class_call) || (cls == class_ret);
    end else if (cls == class_jr) begin
        if (m == 3'd1) begin
            w = taken ? flow_of(bus_read, ab_pc, pc_seq, 1'b0, 1'b1, 1'b1) : end_w;
        end else if (m == 3'd2) begin
            w = end_w;
        end
    end else if (cls == class_jp) begin
        case (m)
            3'd1: w = flow_of(bus_read, ab_pc, pc_seq, 1'b0, 1'b0, 1'b1);
            3'd2: w = taken ? flow_of(bus_idle, ab_pc, pc_temp, 1'b1, 1'b0, 1'b1) : end_w;
            3'd3: w = end_w;
            default: ;
        endcase
    end else if (cls == class_call) begin
        case (m)
            3'd1: w = flow_of(bus_read, ab_pc, pc_seq, 1'b0, 1'b0, 1'b1);
            3'd2: w = taken ? flow_of(bus_idle, ab_pc, pc_seq, 1'b0, 1'b0, 1'b1) : end_w;
            3'd3: w = flow_of(bus_write, ab_sp, pc_seq, 1'b0, 1'b0, 1'b1);
            3'd4: w = flow_of(bus_write, ab_sp, pc_temp, 1'b1, 1'b0, 1'b1);
            3'd5: w = end_w;
            default: ;
        endcase
    end else if (cls == class_ret) begin
        case (m)
            3'd1: w = taken ? flow_of(bus_read, ab_sp, pc_seq, 1'b0, 1'b0, 1'b1) : end_w;
            3'd2: w = flow_of(bus_read, ab_sp, pc_seq, 1'b0, 1'b0, 1'b1);
            3'd3: w = flow_of(bus_idle, ab_pc, pc_stack, 1'b1, 1'b0, 1'b1);
            3'd4: w = end_w;
            default: ;
        endcase
    end
    return w;
endfunction

function automatic ctrl_word_t expected_ctrl(input logic [7:0] opc, input logic [2:0] m,
                                             input logic z, input logic c);
    dp_word_t   d;
    flow_word_t f;
    ctrl_word_t w;
    logic       wb;
    d  = datapath_word(opc);
    f  = flow_expect(decode_class(opc), cond_taken(branch_cond(opc), z, c), m);
    wb = !f.next && !f.halt && !f.stop;
    w  = {d, f};   // Datapath fields lead
    w.rf_we    = d.rf_we && wb;
    w.flags_we = d.flags_we && wb;
    return w;
endfunction

`endif

// File: test/tb_cpu_control.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_control;

    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    localparam int n_instr     = 400;
    localparam int cycle_limit = n_instr * 8 + 20;

    logic       clk;
    logic       arst_n;
    logic [7:0] opcode_early;
    logic [2:0] m_cycle;
    logic       f_z;
    logic       f_c;
    ctrl_word_t ctrl;

    integer seed;
    int     cycles = 0;

    `include "tb_control_model.svh"

    tb_clock_gen #(.half_period(20), .reset_cycles(4)) u_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    cpu_control uut (
        .clk          (clk),
        .arst_n       (arst_n),
        .opcode_early (opcode_early),
        .m_cycle      (m_cycle),
        .f_z          (f_z),
        .f_c          (f_c),
        .ctrl         (ctrl)
    );

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $fatal(1, "Timeout");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    task automatic check_field(input string name, input logic [7:0] got,
                               input logic [7:0] want);
        if (got !== want) begin
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
            $display("*** TEST FAILED ***");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_ctrl(input ctrl_word_t want);
        check_field("ctrl.alu_op", 8'(ctrl.alu_op), 8'(want.alu_op));
        check_field("ctrl.rf_rd_sel", 8'(ctrl.rf_rd_sel), 8'(want.rf_rd_sel));
        check_field("ctrl.rf_wr_sel", 8'(ctrl.rf_wr_sel), 8'(want.rf_wr_sel));
        check_field("ctrl.rf_we", 8'(ctrl.rf_we), 8'(want.rf_we));
        check_field("ctrl.flags_we", 8'(ctrl.flags_we), 8'(want.flags_we));
        check_field("ctrl.bus_op", 8'(ctrl.bus_op), 8'(want.bus_op));
        check_field("ctrl.ab_src", 8'(ctrl.ab_src), 8'(want.ab_src));
        check_field("ctrl.pc_src", 8'(ctrl.pc_src), 8'(want.pc_src));
        check_field("ctrl.pc_we", 8'(ctrl.pc_we), 8'(want.pc_we));
        check_field("ctrl.pc_jr", 8'(ctrl.pc_jr), 8'(want.pc_jr));
        check_field("ctrl.next", 8'(ctrl.next), 8'(want.next));
        check_field("ctrl.halt", 8'(ctrl.halt), 8'(want.halt));
        check_field("ctrl.stop", 8'(ctrl.stop), 8'(want.stop));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic shuffle_flags();
        logic [31:0] r;
        r   = $random(seed);
        f_z = r[7];
        f_c = r[12];
    endtask

    task automatic pick_opcode(output logic [7:0] opc);
        logic [31:0] r;
        logic [31:0] v;
        logic        uncond;
        r      = $random(seed);
        v      = $random(seed);
        uncond = (v[3:2] == 2'b00);
        case (r[3:0])
            4'd0, 4'd1, 4'd2: opc = {2'b01, v[5:0]};   // Loads, some with (HL)
            4'd3, 4'd4, 4'd5: opc = {2'b10, v[5:0]};
            4'd6: opc = v[1] ? (v[0] ? 8'h76 : 8'h10) : 8'h00;
            4'd7, 4'd8: opc = uncond ? 8'h18 : {3'b001, v[1:0], 3'b000};
            4'd9, 4'd10: opc = uncond ? 8'hc3 : {3'b110, v[1:0], 3'b010};
            4'd11, 4'd12: opc = uncond ? 8'hcd : {3'b110, v[1:0], 3'b100};
            4'd13, 4'd14: opc = uncond ? 8'hc9 : {3'b110, v[1:0], 3'b000};
            default: opc = v[15:8];   // Anything, mostly unlisted
        endcase
    endtask

    initial begin
        logic [7:0]  opc;
        logic [31:0] r;
        int          step;
        int          trap_at;
        int          n_traps;
        logic        done;
        seed         = 32'hd624_8432;
        n_traps      = 0;
        opcode_early = 8'h00;
        m_cycle      = 3'd0;
        f_z          = 1'b0;
        f_c          = 1'b0;

        @(posedge arst_n);
        @(negedge clk);
        check_ctrl(expected_ctrl(8'h00, 3'd0, f_z, f_c));   // NOP fetch after reset

        for (int i = 0; i < n_instr; i++) begin
            pick_opcode(opc);
            r       = $random(seed);
            trap_at = (r[2:0] == 3'd0) ? int'(r[4:3]) : -1;
            step    = 0;
            opcode_early = opc;
            m_cycle      = (trap_at == 0) ? {2'b11, r[5]} : 3'd0;
            shuffle_flags();
            done = 1'b0;
            while (!done) begin
                @(negedge clk);
                check_ctrl(expected_ctrl(opc, m_cycle, f_z, f_c));
                if (m_cycle >= 3'd6) begin
                    n_traps++;
                    done = 1'b1;
                end else if (!ctrl.next) begin
                    done = 1'b1;
                end else begin
                    step++;
                    m_cycle = (step == trap_at) ? {2'b11, r[5]} : 3'(step);
                    shuffle_flags();
                end
            end
        end

        $display("Ran %0d instructions, %0d with a forced m_cycle trap", n_instr, n_traps);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
